// File: rtl/cart_types_pkg.sv
// ************************************************
// Cartridge type package
// Type numbers from the CRT header, bank table
// sizes, the CRT bank record and the mapper state
// ************************************************

package cart_types_pkg;

	// CRT hardware type numbers
	localparam logic [15:0] CART_GENERIC     = 16'd0;
	localparam logic [15:0] CART_OCEAN       = 16'd5;
	localparam logic [15:0] CART_EPYX        = 16'd10;
	localparam logic [15:0] CART_MAGIC_DESK  = 16'd19;
	localparam logic [15:0] CART_EASYFLASH   = 16'd32;
	localparam logic [15:0] CART_EASYFLASH_X = 16'd33;   // XBank layout

	localparam int BANK_SLOTS = 64;                     // Entries per bank table

	// 8K bank number inside a 1 MB ROM image
	typedef logic [6:0] bank_t;

	// One CHIP packet as seen by the CRT loader
	typedef struct packed {
		logic [15:0] num;     // Bank number
		logic [15:0] laddr;   // Loading address on the C64 side
		logic [15:0] size;    // Packet length in bytes
		logic [24:0] raddr;   // Packet location in SDRAM
	} crt_bank_t;

	// Live mapping configuration
	typedef struct packed {
		bank_t bank_lo;       // ROML bank
		bank_t bank_hi;       // ROMH bank
		bank_t io_bank;       // Bank behind DExx/DFxx
		logic  ioe_ena;
		logic  iof_ena;
		logic  iof_wr_ena;
		logic  romL_we;       // ROML window backed by cart RAM
		logic  exrom_ovr;
		logic  game_ovr;
	} map_state_t;

endpackage

// File: rtl/c64_bus_pkg.sv
// ************************************************
// C64 bus package
// CPU bus bundle, I/O strobes, SDRAM request and
// the fixed bases of the ROM and RAM areas
// ************************************************

package c64_bus_pkg;

	// CPU side of the expansion port
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rom_l;
		logic        rom_h;
		logic        ioe;
		logic        iof;
		logic        mem_write;
		logic        mem_ce;
	} c64_bus_t;

	// First cycle of an I/O window access
	typedef struct packed {
		logic ioe_stb;
		logic iof_stb;
	} io_strobe_t;

	typedef struct packed {
		logic [24:0] addr;
		logic        write;
		logic        ce;
	} sdram_req_t;

	// ROM banks live at 0x100000 (1 MB max), bits 24..20
	localparam logic [4:0] ROM_AREA_MSB = 5'b00001;

	// RAM banks live at 0x010000 (64 KB max), bits 24..16
	localparam logic [8:0] RAM_AREA_TAG = 9'b0_0000_0001;

endpackage

// File: rtl/bank_table.sv
// ************************************************
// Bank tables
// Holds the ROML and ROMH bank lookup tables and
// fills them from CRT bank records while loading
// ************************************************

`timescale 1ns/100ps

module bank_table #(
	parameter int BANK_SLOTS = 64
) (
	input  logic                     clk32,
	input  cart_types_pkg::crt_bank_t cart_bank,
	input  logic                     cart_bank_wr,
	input  logic [5:0]               sel,
	output cart_types_pkg::bank_t    lo_entry,
	output cart_types_pkg::bank_t    hi_entry
);

	cart_types_pkg::bank_t lo_tab [BANK_SLOTS];
	cart_types_pkg::bank_t hi_tab [BANK_SLOTS];

	logic [5:0]            idx;
	cart_types_pkg::bank_t raw_bank;

	assign idx      = cart_bank.num[5:0];
	assign raw_bank = cart_bank.raddr[19:13];   // 8K granularity inside the ROM area

	always_ff @(posedge clk32) begin
		if (cart_bank_wr && (cart_bank.num < BANK_SLOTS)) begin
			if (cart_bank.laddr <= 16'h8000) begin
				lo_tab[idx] <= raw_bank;
				// 16K packet spills into the ROMH window
				if (cart_bank.size > 16'h2000)
					hi_tab[idx] <= raw_bank + 7'd1;
			end else begin
				hi_tab[idx] <= raw_bank;   // A000/E000 packets
			end
		end
	end

	assign lo_entry = lo_tab[sel];
	assign hi_entry = hi_tab[sel];

endmodule

// File: rtl/discharge_timer.sv
// ************************************************
// Epyx discharge timer
// Models the Fastload capacitor that keeps the cart
// visible for a while after the last access
// ************************************************

`timescale 1ns/100ps

module discharge_timer #(
	parameter int DISCHARGE_CYCLES = 16384
) (
	input  logic clk32,
	input  logic reset_n,
	input  logic charge,
	output logic expired
);

	localparam int CNT_W = $clog2(DISCHARGE_CYCLES + 1);

	logic [CNT_W-1:0] count;
	logic             armed;

	always_ff @(posedge clk32) begin
		if (reset_n) begin
			armed   <= 1'b0;
			expired <= 1'b0;
			count   <= '0;
		end else if (charge) begin
			armed   <= 1'b1;                            // Capacitor charged again
			expired <= 1'b0;
			count   <= CNT_W'(DISCHARGE_CYCLES);
		end else if (armed) begin
			if (count != '0)
				count <= count - 1'b1;
			else
				expired <= 1'b1;                        // Held until the next charge
		end
	end

endmodule

// File: rtl/mapper_control.sv
// ************************************************
// Mapper control
// Per cartridge type FSM that steers the ROM banks,
// the EXROM/GAME lines and the I/O windows
// ************************************************

`timescale 1ns/100ps

module mapper_control (
	input  logic                       clk32,
	input  logic                       reset_n,
	input  logic [15:0]                cart_id,
	input  logic [7:0]                 cart_exrom,
	input  logic [7:0]                 cart_game,
	input  c64_bus_pkg::c64_bus_t      bus,
	input  cart_types_pkg::bank_t      lo_entry,
	input  cart_types_pkg::bank_t      hi_entry,
	input  logic                       expired,
	output logic [5:0]                 sel,
	output logic                       charge,
	output c64_bus_pkg::io_strobe_t    stb,
	output cart_types_pkg::map_state_t map
);

	typedef enum logic [1:0] {
		ST_RESET,
		ST_INIT,
		ST_RUN
	} state_t;

	// Cart unplugged: both lines released, nothing mapped
	localparam cart_types_pkg::map_state_t MAP_IDLE = '{
		exrom_ovr: 1'b1,
		game_ovr:  1'b1,
		default:   '0
	};

	state_t      state;
	logic [15:0] old_id;
	logic        old_ioe;
	logic        old_iof;
	logic        ioe_wr;
	logic        is_ef;

	assign is_ef = (cart_id == cart_types_pkg::CART_EASYFLASH) ||
	               (cart_id == cart_types_pkg::CART_EASYFLASH_X);

	// ************************************************
	// I/O strobes
	// ************************************************
	always_ff @(posedge clk32) begin
		old_id  <= cart_id;
		old_ioe <= bus.ioe;
		old_iof <= bus.iof;
	end

	assign stb.ioe_stb = bus.ioe & ~old_ioe;
	assign stb.iof_stb = bus.iof & ~old_iof;
	assign ioe_wr      = stb.ioe_stb & bus.mem_write;

	// EasyFlash picks its bank pair straight from the written byte
	assign sel    = (state == ST_RUN && is_ef) ? bus.data[5:0] : 6'd0;
	assign charge = (cart_id == cart_types_pkg::CART_EPYX) & (bus.ioe | bus.rom_l);

	// ************************************************
	// Type FSM
	// ************************************************
	always_ff @(posedge clk32) begin
		if (reset_n || (old_id != cart_id)) begin   // New cart acts as a reset
			state <= ST_RESET;
			map   <= MAP_IDLE;
		end else if (state == ST_RESET) begin
			state <= ST_INIT;
		end else begin
			state <= ST_RUN;
			case (cart_id)
				cart_types_pkg::CART_GENERIC: begin
					// 8K, 16K or ultimax as given by the CRT header
					map.exrom_ovr <= cart_exrom[0];
					map.game_ovr  <= cart_game[0];
					map.bank_lo   <= lo_entry;
					map.bank_hi   <= hi_entry;
				end
				cart_types_pkg::CART_OCEAN: begin
					map.exrom_ovr <= 1'b0;
					map.game_ovr  <= 1'b0;
					if (ioe_wr) begin
						map.bank_lo <= {1'b0, bus.data[5:0]};   // Mirrored at 8000 and A000
						map.bank_hi <= {1'b0, bus.data[5:0]};
					end
				end
				cart_types_pkg::CART_EPYX: begin
					map.game_ovr <= 1'b1;
					map.iof_ena  <= 1'b1;                   // Last ROM page shows at DFxx
					map.io_bank  <= '0;
					if (state == ST_INIT || charge)
						map.exrom_ovr <= 1'b0;
					else if (expired)
						map.exrom_ovr <= 1'b1;               // Capacitor empty, cart drops out
				end
				cart_types_pkg::CART_MAGIC_DESK: begin
					if (state == ST_INIT) begin
						map.game_ovr  <= 1'b1;
						map.exrom_ovr <= 1'b0;
						map.bank_lo   <= '0;
					end else if (ioe_wr) begin
						map.bank_lo   <= {3'b000, bus.data[3:0]};
						map.exrom_ovr <= bus.data[7];        // Bit 7 hides the cart
					end
				end
				cart_types_pkg::CART_EASYFLASH,
				cart_types_pkg::CART_EASYFLASH_X: begin
					if (state == ST_INIT) begin
						map.iof_ena    <= 1'b1;
						map.iof_wr_ena <= 1'b1;              // 256 bytes of RAM at DFxx
						map.io_bank    <= '0;
						map.game_ovr   <= 1'b0;
						// Only the original EasyFlash boots in ultimax mode
						map.exrom_ovr  <= (cart_id == cart_types_pkg::CART_EASYFLASH);
						map.bank_lo    <= lo_entry;
						map.bank_hi    <= hi_entry;
					end else if (ioe_wr) begin
						if (bus.addr[1]) begin
							// DE02 control register, jumper assumed in boot position
							map.game_ovr  <= bus.data[2] & ~bus.data[0];
							map.exrom_ovr <= ~bus.data[1];
						end else begin
							map.bank_lo <= lo_entry;          // DE00 bank register
							map.bank_hi <= hi_entry;
						end
					end
				end
				default: ;                                  // Unknown type stays inactive
			endcase
		end
	end

endmodule

// File: rtl/addr_translate.sv
// ************************************************
// Address translation
// Redirects CPU accesses in the ROM and I/O windows
// into the CRT image and cart RAM held in SDRAM
// ************************************************

`timescale 1ns/100ps

module addr_translate (
	input  logic                       reset_n,
	input  c64_bus_pkg::c64_bus_t      bus,
	input  cart_types_pkg::map_state_t map,
	input  c64_bus_pkg::io_strobe_t    stb,
	output c64_bus_pkg::sdram_req_t    mem
);

	logic cs_ioe;
	logic cs_iof;

	// Upper address bits 24..13 for a bank in the ROM or RAM area
	function automatic logic [11:0] area_bank(input cart_types_pkg::bank_t bank, input logic ram);
		area_bank = ram ? {c64_bus_pkg::RAM_AREA_TAG, bank[2:0]}
		                : {c64_bus_pkg::ROM_AREA_MSB, bank};
	endfunction

	// DExx has no RAM mode in any supported cart
	assign cs_ioe = bus.ioe & ~bus.mem_write & map.ioe_ena;
	assign cs_iof = bus.iof & (bus.mem_write ? map.iof_wr_ena : map.iof_ena);

	always_comb begin
		mem.addr = {9'd0, bus.addr};
		mem.ce   = bus.mem_ce | (cs_ioe & stb.ioe_stb) | (cs_iof & stb.iof_stb);

		// No RAM under ROML in ultimax mode, so such writes go nowhere
		mem.write = bus.mem_write &
		            ~(bus.rom_l & ~map.romL_we & map.exrom_ovr & ~map.game_ovr);

		if (!reset_n) begin
			if (bus.rom_h && !bus.mem_write)
				mem.addr[24:13] = area_bank(map.bank_hi, 1'b0);
			if (bus.rom_l && (map.romL_we || !bus.mem_write))
				mem.addr[24:13] = area_bank(map.bank_lo, map.romL_we);

			if (cs_ioe)
				mem.addr[24:13] = area_bank(map.io_bank, 1'b0);        // DExx
			if (cs_iof)
				mem.addr[24:13] = area_bank(map.io_bank, map.iof_wr_ena); // DFxx
		end
	end

endmodule

// File: rtl/cartridge.sv
// ************************************************
// C64 cartridge mapper
// Bank tables, type control, Epyx timer and the
// bus to SDRAM address translation
// ************************************************

`timescale 1ns/100ps

module cartridge #(
	parameter int BANK_SLOTS       = cart_types_pkg::BANK_SLOTS,
	parameter int DISCHARGE_CYCLES = 16384
) (
	input  logic                      clk32,
	input  logic                      reset_n,
	input  logic                      cart_loading,
	input  logic [15:0]               cart_id,
	input  logic [7:0]                cart_exrom,
	input  logic [7:0]                cart_game,
	input  cart_types_pkg::crt_bank_t cart_bank,
	input  logic                      cart_bank_wr,
	input  c64_bus_pkg::c64_bus_t     bus,
	output logic                      exrom,
	output logic                      game,
	output c64_bus_pkg::sdram_req_t   mem
);

	cart_types_pkg::bank_t      lo_entry;
	cart_types_pkg::bank_t      hi_entry;
	cart_types_pkg::map_state_t map;
	c64_bus_pkg::io_strobe_t    stb;
	logic [5:0]                 sel;
	logic                       charge;
	logic                       expired;

	// Records only count while a CRT image is being loaded
	wire bank_wr = cart_bank_wr & cart_loading;

	assign exrom = map.exrom_ovr;
	assign game  = map.game_ovr;

	bank_table #(
		.BANK_SLOTS(BANK_SLOTS)
	) u_bank_table (
		.clk32       (clk32),
		.cart_bank   (cart_bank),
		.cart_bank_wr(bank_wr),
		.sel         (sel),
		.lo_entry    (lo_entry),
		.hi_entry    (hi_entry)
	);

	discharge_timer #(
		.DISCHARGE_CYCLES(DISCHARGE_CYCLES)
	) u_discharge_timer (
		.clk32  (clk32),
		.reset_n(reset_n),
		.charge (charge),
		.expired(expired)
	);

	mapper_control u_mapper_control (
		.clk32     (clk32),
		.reset_n   (reset_n),
		.cart_id   (cart_id),
		.cart_exrom(cart_exrom),
		.cart_game (cart_game),
		.bus       (bus),
		.lo_entry  (lo_entry),
		.hi_entry  (hi_entry),
		.expired   (expired),
		.sel       (sel),
		.charge    (charge),
		.stb       (stb),
		.map       (map)
	);

	addr_translate u_addr_translate (
		.reset_n(reset_n),
		.bus    (bus),
		.map    (map),
		.stb    (stb),
		.mem    (mem)
	);

endmodule

// File: tests/tb_clock.sv
// ************************************************
// Testbench clock and reset
// 10 ns clock, reset held for a few cycles
// ************************************************

`timescale 1ns/100ps

module tb_clock #(
	parameter int RESET_CYCLES = 3
) (
	output logic clk32,
	output logic reset_n
);

	initial begin
		clk32 = 1'b0;
		forever #5 clk32 = ~clk32;   // 10 ns period
	end

	// Design sits in reset while reset_n is high
	initial begin
		reset_n = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk32);
		#1 reset_n = 1'b0;
	end

endmodule

// File: tests/tb_cartridge.sv
// ************************************************
// Cartridge mapper testbench
// Loads random CRT records, runs each cart type
// and checks EXROM/GAME and the SDRAM requests
// ************************************************

`timescale 1ns/100ps

module tb_cartridge;

	localparam int          DISCHARGE  = 64;
	localparam int          MAX_CYCLES = 4000;   // Tests take about 1500 cycles at most
	localparam logic [24:0] ROM_BASE   = 25'h100000;
	localparam logic [24:0] RAM_BASE   = 25'h010000;

	logic                      clk32;
	logic                      reset_n;
	logic                      cart_loading;
	logic [15:0]               cart_id;
	logic [7:0]                cart_exrom;
	logic [7:0]                cart_game;
	cart_types_pkg::crt_bank_t cart_bank;
	logic                      cart_bank_wr;
	c64_bus_pkg::c64_bus_t     bus;
	logic                      exrom;
	logic                      game;
	c64_bus_pkg::sdram_req_t   mem;

	cart_types_pkg::bank_t exp_lo [64];   // Expected ROML table
	cart_types_pkg::bank_t exp_hi [64];   // Expected ROMH table

	logic [31:0] rng;
	int          errors;
	int          checks;
	int          tests;
	int          mark;
	int          cycles;

	tb_clock #(.RESET_CYCLES(3)) u_tb_clock (.clk32(clk32), .reset_n(reset_n));

	cartridge #(
		.DISCHARGE_CYCLES(DISCHARGE)
	) u_cartridge (
		.clk32       (clk32),
		.reset_n     (reset_n),
		.cart_loading(cart_loading),
		.cart_id     (cart_id),
		.cart_exrom  (cart_exrom),
		.cart_game   (cart_game),
		.cart_bank   (cart_bank),
		.cart_bank_wr(cart_bank_wr),
		.bus         (bus),
		.exrom       (exrom),
		.game        (game),
		.mem         (mem)
	);

	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function logic [31:0] lcg_next();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	task automatic tick();
		@(posedge clk32);
		#1;   // Drive point
	endtask

	task automatic bus_idle();
		bus = '0;
	endtask

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("[FAIL] %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %0d %s: %s", tests, name, (errors == mark) ? "passed" : "failed");
		mark = errors;
	endtask

	// Writes one CHIP record and mirrors it into the expected tables
	task automatic load_record(input logic [15:0] number, input logic [15:0] load_addr,
	                           input logic [15:0] length, input logic [24:0] sdram_addr);
		cart_bank.num   = number;
		cart_bank.laddr = load_addr;
		cart_bank.size  = length;
		cart_bank.raddr = sdram_addr;
		cart_bank_wr    = 1'b1;
		if (number < 64) begin
			if (load_addr <= 16'h8000) begin
				exp_lo[number[5:0]] = sdram_addr[19:13];
				if (length > 16'h2000)
					exp_hi[number[5:0]] = sdram_addr[19:13] + 7'd1;   // Upper 8K half
			end else begin
				exp_hi[number[5:0]] = sdram_addr[19:13];
			end
		end
		tick();
		cart_bank_wr = 1'b0;
	endtask

	// IOE write cycle followed by one idle cycle for the map update
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus.addr      = addr;
		bus.data      = data;
		bus.ioe       = 1'b1;
		bus.mem_write = 1'b1;
		tick();
		bus_idle();
		tick();
	endtask

	task automatic rom_read(input logic high, input logic [12:0] off,
	                        input cart_types_pkg::bank_t bank, input string what);
		logic [24:0] want;
		want       = ROM_BASE | {5'd0, bank, off};
		bus.addr   = {high ? 3'b101 : 3'b100, off};
		bus.rom_h  = high;
		bus.rom_l  = ~high;
		bus.mem_ce = 1'b1;
		#1;
		check(mem.addr === want && mem.ce === 1'b1 && mem.write === 1'b0,
		      $sformatf("%s read gave %h, expected %h", what, mem.addr, want));
		tick();
		bus_idle();
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  d;
		logic [24:0] want;
		int          i;
		int          n;

		rng          = 32'hca16_45c9;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		mark         = 0;
		cycles       = 0;
		cart_loading = 1'b0;
		cart_id      = 16'hffff;   // No cart type yet
		cart_exrom   = 8'h00;
		cart_game    = 8'h00;
		cart_bank    = '0;
		cart_bank_wr = 1'b0;
		bus_idle();
		wait (reset_n == 1'b0);
		tick();

		// ************************************************
		// Bank loading and Generic mapping
		// ************************************************
		cart_loading = 1'b1;
		for (i = 0; i < 64; i++) begin
			r = lcg_next();
			load_record(16'(i), 16'h8000, r[31] ? 16'h4000 : 16'h2000, r[24:0]);
			if (!r[31]) begin
				r = lcg_next();
				load_record(16'(i), r[30] ? 16'hE000 : 16'hA000, 16'h2000, r[24:0]);
			end
		end
		// Out of range number that aliases entry 0
		r = lcg_next();
		load_record({r[15:7], 1'b1, 6'd0}, 16'h8000, 16'h4000,
		            {r[24:20], exp_lo[0] + 7'd3, r[12:0]});
		cart_loading = 1'b0;
		r            = lcg_next();
		cart_exrom   = r[7:0];
		cart_game    = r[15:8];
		cart_id      = cart_types_pkg::CART_GENERIC;
		repeat (4) tick();
		check(exrom === cart_exrom[0] && game === cart_game[0],
		      $sformatf("Generic EXROM/GAME %b%b, expected %b%b",
		                exrom, game, cart_exrom[0], cart_game[0]));
		rom_read(1'b0, r[28:16], exp_lo[0], "Generic ROML");
		rom_read(1'b1, r[12:0], exp_hi[0], "Generic ROMH");
		end_test("bank load and Generic");

		// Ocean mirrors one bank into both windows
		cart_id = cart_types_pkg::CART_OCEAN;
		repeat (4) tick();
		r = lcg_next();
		io_write(16'hde00, r[7:0]);
		rom_read(1'b0, r[20:8], {1'b0, r[5:0]}, "Ocean ROML");
		rom_read(1'b1, r[20:8], {1'b0, r[5:0]}, "Ocean ROMH");
		check(exrom === 1'b0 && game === 1'b0,
		      $sformatf("Ocean EXROM/GAME %b%b, expected 00", exrom, game));
		end_test("Ocean");

		cart_id = cart_types_pkg::CART_MAGIC_DESK;
		repeat (4) tick();
		r = lcg_next();
		for (i = 0; i < 2; i++) begin
			d = r[7:0] ^ ((i == 1) ? 8'h80 : 8'h00);   // Both states of the hide bit
			io_write(16'hde00, d);
			check(exrom === d[7] && game === 1'b1,
			      $sformatf("Magic Desk EXROM/GAME %b%b after writing %h", exrom, game, d));
			rom_read(1'b0, r[20:8], {3'b000, d[3:0]}, "Magic Desk ROML");
		end
		end_test("Magic Desk");

		// ************************************************
		// Epyx capacitor
		// ************************************************
		cart_id = cart_types_pkg::CART_EPYX;
		repeat (4) tick();
		r = lcg_next();
		rom_read(1'b0, r[20:8], 7'd0, "Epyx ROML");   // First charge of the capacitor
		n = 0;
		while (exrom !== 1'b1 && n < 80) begin
			tick();
			n++;
		end
		check(exrom === 1'b1, "Epyx EXROM never rose after a ROML access");
		bus.addr = {8'hde, r[7:0]};
		bus.ioe  = 1'b1;
		tick();
		bus_idle();
		check(exrom === 1'b0, "Epyx EXROM was not low after an IOE access");
		n = 0;
		while (exrom !== 1'b1 && n < 80) begin
			tick();
			n++;
		end
		check(n >= 60 && n <= 70,
		      $sformatf("Epyx EXROM rose %0d cycles after the access, expected 60 to 70", n));
		rom_read(1'b0, r[28:16], 7'd0, "Epyx ROML");
		check(exrom === 1'b0, "Epyx EXROM was not low after a ROML access");
		end_test("Epyx");

		// ************************************************
		// EasyFlash
		// ************************************************
		cart_id = cart_types_pkg::CART_EASYFLASH;
		repeat (4) tick();
		check(exrom === 1'b1 && game === 1'b0,
		      $sformatf("EasyFlash boot EXROM/GAME %b%b, expected 10", exrom, game));
		r = lcg_next();
		rom_read(1'b0, r[28:16], exp_lo[0], "EasyFlash boot ROML");
		io_write(16'hde00, r[7:0]);
		rom_read(1'b1, r[20:8], exp_hi[r[5:0]], "EasyFlash ROMH");
		rom_read(1'b0, r[20:8], exp_lo[r[5:0]], "EasyFlash ROML");
		for (i = 0; i < 3; i++) begin
			r = lcg_next();
			io_write(16'hde02, r[7:0]);
			check(game === (r[2] & ~r[0]) && exrom === ~r[1],
			      $sformatf("EasyFlash control %h gave EXROM/GAME %b%b", r[7:0], exrom, game));
		end
		r             = lcg_next();
		bus.addr      = {8'hdf, r[7:0]};
		bus.data      = r[15:8];
		bus.iof       = 1'b1;
		bus.mem_write = 1'b1;
		#1;
		want = RAM_BASE | {12'd0, bus.addr[12:0]};
		check(mem.ce === 1'b1 && mem.write === 1'b1 && mem.addr === want,
		      $sformatf("IOF write gave ce %b addr %h, expected 1 and %h", mem.ce, mem.addr, want));
		tick();
		check(mem.ce === 1'b0, $sformatf("mem.ce is %b after the IOF strobe cycle", mem.ce));
		bus_idle();
		tick();
		end_test("EasyFlash");

		// Generic in ultimax mode
		cart_exrom = 8'h01;
		cart_game  = 8'h00;
		cart_id    = cart_types_pkg::CART_GENERIC;
		repeat (4) tick();
		check(exrom === 1'b1 && game === 1'b0,
		      $sformatf("Ultimax EXROM/GAME %b%b, expected 10", exrom, game));
		r             = lcg_next();
		bus.addr      = {3'b100, r[12:0]};
		bus.data      = r[23:16];
		bus.rom_l     = 1'b1;
		bus.mem_write = 1'b1;
		bus.mem_ce    = 1'b1;
		#1;
		check(mem.write === 1'b0 && mem.ce === 1'b1,
		      $sformatf("ROML write in ultimax gave write %b, expected 0", mem.write));
		tick();
		bus_idle();
		bus.addr      = {3'b010, r[28:16]};
		bus.mem_write = 1'b1;
		bus.mem_ce    = 1'b1;
		#1;
		check(mem.write === 1'b1 && mem.addr === {9'd0, bus.addr},
		      $sformatf("RAM write gave write %b addr %h", mem.write, mem.addr));
		tick();
		bus_idle();
		end_test("ultimax write protection");

		$display("Tests: %0d, checks: %0d, failures: %0d", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: files.f
rtl/cart_types_pkg.sv
rtl/c64_bus_pkg.sv
rtl/bank_table.sv
rtl/discharge_timer.sv
rtl/mapper_control.sv
rtl/addr_translate.sv
rtl/cartridge.sv
tests/tb_clock.sv
tests/tb_cartridge.sv

// File: Bender.yml
package:
  name: c64_cartridge

sources:
  - rtl/cart_types_pkg.sv
  - rtl/c64_bus_pkg.sv
  - rtl/bank_table.sv
  - rtl/discharge_timer.sv
  - rtl/mapper_control.sv
  - rtl/addr_translate.sv
  - rtl/cartridge.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_cartridge.sv
